// ==== include/uart_params.svh ====
// UART parameters covering bus widths, FIFO depth and register offsets
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// APB bus widths
`define UART_APB_ADDR_W 32
`define UART_APB_DATA_W 32

// Entries in each of the transmit and receive FIFOs
`define UART_FIFO_DEPTH 16

// Width of the bit-period divider register
`define UART_DIV_W 16

// Register offsets
`define UART_CLK_DIV_ADDR 32'h0000_0000
`define UART_CONTROL_ADDR 32'h0000_0004
`define UART_STATUS_ADDR  32'h0000_0008
`define UART_TX_DATA_ADDR 32'h0000_000C
`define UART_RX_DATA_ADDR 32'h0000_0010

`endif

// ==== hw/uart_pkg.sv ====
// Shared types of the APB UART: bus structs, register fields and the receive word
`include "uart_params.svh"

package uart_pkg;

    // APB request as seen by the slave
    typedef struct packed {
        logic                          psel;
        logic                          penable;
        logic                          pwrite;
        logic [`UART_APB_ADDR_W-1:0]   paddr;
        logic [`UART_APB_DATA_W-1:0]   pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`UART_APB_DATA_W-1:0]   prdata;
        logic                          pready;
        logic                          pslverr;
    } apb_rsp_t;

    // Control register with parity_even in bit 0
    typedef struct packed {
        logic [`UART_APB_DATA_W-5:0]   rsvd;
        logic                          rx_reset;
        logic                          tx_reset;
        logic                          parity_odd;  // Wins over parity_even when both set
        logic                          parity_even;
    } uart_control_t;

    // Status register with rx_fifo_empty in bit 0
    typedef struct packed {
        logic [`UART_APB_DATA_W-6:0]   rsvd;
        logic                          parity_err;
        logic                          tx_fifo_full;
        logic                          rx_fifo_full;
        logic                          tx_fifo_empty;
        logic                          rx_fifo_empty;
    } uart_status_t;

    // Received byte with its parity check result
    typedef struct packed {
        logic                          parity_err;
        logic [7:0]                    data;
    } rx_word_t;

endpackage

// ==== hw/uart_fifo.sv ====
// Synchronous valid/ready FIFO with registered full and empty flags
`timescale 1ns/1ps

module uart_fifo #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  payload_t in_data_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    output payload_t out_data_o,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output logic     full_o,
    output logic     empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;
    logic             push;
    logic             pop;

    assign push        = in_valid_i & ~full_o;
    assign pop         = out_ready_i & ~empty_o;
    assign in_ready_o  = ~full_o;
    assign out_valid_o = ~empty_o;
    assign out_data_o  = mem[rd_ptr];

    always_comb begin
        count_nxt = count;
        if (push && !pop) begin
            count_nxt = count + 1'b1;
        end else if (pop && !push) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            full_o  <= 1'b0;
            empty_o <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count   <= count_nxt;
            full_o  <= (count_nxt == CNT_W'(DEPTH));  // Flags follow the next occupancy
            empty_o <= (count_nxt == '0);
        end
    end

endmodule

// ==== hw/uart_tx.sv ====
// UART serializer that sends start, eight data bits LSB first, optional parity and stop
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tx (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic [`UART_DIV_W-1:0]  clk_div_i,
    input  uart_pkg::uart_control_t control_i,
    input  logic [7:0]              data_i,
    input  logic                    valid_i,
    output logic                    ready_o,
    output logic                    uart_tx_o
);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    tx_state_e              state;
    logic [`UART_DIV_W-1:0] cnt;
    logic [2:0]             bit_idx;
    logic [7:0]             shreg;
    logic                   par_bit;
    logic                   par_en;
    logic                   bit_end;
    logic                   tx_q;

    assign ready_o   = (state == TX_IDLE);
    assign bit_end   = (cnt >= clk_div_i);  // Each bit lasts divider plus one cycles
    assign par_en    = control_i.parity_even | control_i.parity_odd;
    assign uart_tx_o = tx_q;

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            shreg   <= data_i;
            par_bit <= ^data_i ^ control_i.parity_odd;  // Odd parity inverts the even bit
        end else if (state == TX_DATA && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            tx_q    <= 1'b1;
        end else begin
            cnt <= (state == TX_IDLE || bit_end) ? '0 : cnt + 1'b1;
            case (state)
                TX_IDLE: if (valid_i) begin
                    state <= TX_START;
                    tx_q  <= 1'b0;
                end
                TX_START: if (bit_end) begin
                    state <= TX_DATA;
                    tx_q  <= shreg[0];
                end
                TX_DATA: if (bit_end) begin
                    bit_idx <= bit_idx + 1'b1;  // Wraps back to zero after bit 7
                    if (bit_idx == 3'd7) begin
                        state <= par_en ? TX_PARITY : TX_STOP;
                        tx_q  <= par_en ? par_bit : 1'b1;
                    end else begin
                        tx_q <= shreg[1];
                    end
                end
                TX_PARITY: if (bit_end) begin
                    state <= TX_STOP;
                    tx_q  <= 1'b1;
                end
                TX_STOP: if (bit_end) begin
                    state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/uart_rx.sv ====
// UART deserializer that finds start bits, samples bit centres and checks parity
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic [`UART_DIV_W-1:0]  clk_div_i,
    input  uart_pkg::uart_control_t control_i,
    input  logic                    uart_rx_i,
    output uart_pkg::rx_word_t      word_o,
    output logic                    valid_o,
    input  logic                    ready_i
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    rx_state_e              state;
    logic [`UART_DIV_W-1:0] cnt;
    logic [2:0]             bit_idx;
    logic [7:0]             shreg;
    logic                   perr;
    logic                   par_en;
    logic                   sample;
    logic                   rx_meta;
    logic                   rx_sync;
    logic                   rx_prev;

    assign par_en = control_i.parity_even | control_i.parity_odd;

    // Start bit is checked after half a period, later bits a full period apart
    assign sample = (state == RX_START) ? (cnt >= (clk_div_i >> 1)) : (cnt >= clk_div_i);

    always_ff @(posedge clk_i) begin
        if (state == RX_IDLE) begin
            perr <= 1'b0;
        end
        if (state == RX_DATA && sample) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
        if (state == RX_PARITY && sample) begin
            perr <= rx_sync ^ (^shreg) ^ control_i.parity_odd;
        end
        if (state == RX_STOP && sample) begin
            word_o.data       <= shreg;
            word_o.parity_err <= perr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            valid_o <= 1'b0;
        end else begin
            rx_meta <= uart_rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
            valid_o <= 1'b0;
            cnt     <= (state == RX_IDLE || sample) ? '0 : cnt + 1'b1;
            case (state)
                RX_IDLE: if (rx_prev && !rx_sync) begin
                    state <= RX_START;
                end
                RX_START: if (sample) begin
                    state <= rx_sync ? RX_IDLE : RX_DATA;  // Glitch shorter than half a bit
                end
                RX_DATA: if (sample) begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        state <= par_en ? RX_PARITY : RX_STOP;
                    end
                end
                RX_PARITY: if (sample) begin
                    state <= RX_STOP;
                end
                RX_STOP: if (sample) begin
                    state   <= RX_IDLE;
                    valid_o <= ready_i;  // Byte is lost when the FIFO is full
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/uart_apb_regs.sv ====
// APB register block that holds the UART configuration and bridges data accesses to the FIFOs
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_apb_regs (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  uart_pkg::apb_req_t        apb_req_i,
    output uart_pkg::apb_rsp_t        apb_rsp_o,
    output logic [7:0]                tx_data_o,
    output logic                      tx_valid_o,
    input  logic                      tx_ready_i,
    input  uart_pkg::rx_word_t        rx_word_i,
    input  logic                      rx_valid_i,
    output logic                      rx_ready_o,
    input  logic                      tx_fifo_empty_i,
    input  logic                      tx_fifo_full_i,
    input  logic                      rx_fifo_full_i,
    output logic [`UART_DIV_W-1:0]    clk_div_o,
    output uart_pkg::uart_control_t   control_o
);

    logic                   access;
    logic                   wr_en;
    logic                   rd_en;
    logic                   tx_sel;
    logic                   rx_sel;
    uart_pkg::uart_status_t status;

    assign access = apb_req_i.psel & apb_req_i.penable;
    assign wr_en  = access & apb_req_i.pwrite;
    assign rd_en  = access & ~apb_req_i.pwrite;
    assign tx_sel = wr_en && (apb_req_i.paddr == `UART_TX_DATA_ADDR);
    assign rx_sel = rd_en && (apb_req_i.paddr == `UART_RX_DATA_ADDR);

    // Data accesses map straight onto the FIFO streams, APB keeps them stable while stalled
    assign tx_data_o  = apb_req_i.pwdata[7:0];
    assign tx_valid_o = tx_sel;
    assign rx_ready_o = rx_sel;

    always_comb begin
        status               = '0;
        status.rx_fifo_empty = ~rx_valid_i;
        status.tx_fifo_empty = tx_fifo_empty_i;
        status.rx_fifo_full  = rx_fifo_full_i;
        status.tx_fifo_full  = tx_fifo_full_i;
        status.parity_err    = rx_valid_i & rx_word_i.parity_err;  // Flag of the head byte
    end

    always_comb begin
        apb_rsp_o        = '0;
        apb_rsp_o.pready = 1'b1;
        if (tx_sel) begin
            apb_rsp_o.pready = tx_ready_i;
        end else if (rx_sel) begin
            apb_rsp_o.pready = rx_valid_i;
        end

        if (rd_en) begin
            case (apb_req_i.paddr)
                `UART_CLK_DIV_ADDR: apb_rsp_o.prdata[`UART_DIV_W-1:0] = clk_div_o;
                `UART_CONTROL_ADDR: apb_rsp_o.prdata = control_o;
                `UART_STATUS_ADDR:  apb_rsp_o.prdata = status;
                `UART_RX_DATA_ADDR: apb_rsp_o.prdata[7:0] = rx_word_i.data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            clk_div_o <= '0;
            control_o <= '0;
        end else if (wr_en) begin
            case (apb_req_i.paddr)
                `UART_CLK_DIV_ADDR: clk_div_o <= apb_req_i.pwdata[`UART_DIV_W-1:0];
                `UART_CONTROL_ADDR: control_o <= apb_req_i.pwdata;
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/apb_uart.sv ====
// APB UART top level with register block, transmit and receive FIFOs and the serial engines
`timescale 1ns/1ps
`include "uart_params.svh"

module apb_uart (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  uart_pkg::apb_req_t apb_req_i,
    output uart_pkg::apb_rsp_t apb_rsp_o,
    input  logic               uart_rx_i,
    output logic               uart_tx_o
);

    logic [`UART_DIV_W-1:0]  clk_div;
    uart_pkg::uart_control_t control;
    logic                    tx_rstn;
    logic                    rx_rstn;
    logic [7:0]              tx_wr_data;
    logic                    tx_wr_valid;
    logic                    tx_wr_ready;
    logic [7:0]              ser_data;
    logic                    ser_valid;
    logic                    ser_ready;
    uart_pkg::rx_word_t      des_word;
    logic                    des_valid;
    logic                    des_ready;
    uart_pkg::rx_word_t      rx_rd_word;
    logic                    rx_rd_valid;
    logic                    rx_rd_ready;
    logic                    tx_fifo_empty;
    logic                    tx_fifo_full;
    logic                    rx_fifo_full;

    // Software can hold either path in reset through the control register
    assign tx_rstn = rstn_i & ~control.tx_reset;
    assign rx_rstn = rstn_i & ~control.rx_reset;

    uart_apb_regs u_regs (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .apb_req_i       (apb_req_i),
        .apb_rsp_o       (apb_rsp_o),
        .tx_data_o       (tx_wr_data),
        .tx_valid_o      (tx_wr_valid),
        .tx_ready_i      (tx_wr_ready),
        .rx_word_i       (rx_rd_word),
        .rx_valid_i      (rx_rd_valid),
        .rx_ready_o      (rx_rd_ready),
        .tx_fifo_empty_i (tx_fifo_empty),
        .tx_fifo_full_i  (tx_fifo_full),
        .rx_fifo_full_i  (rx_fifo_full),
        .clk_div_o       (clk_div),
        .control_o       (control)
    );

    uart_fifo #(
        .DEPTH     (`UART_FIFO_DEPTH),
        .payload_t (logic [7:0])
    ) u_tx_fifo (
        .clk_i       (clk_i),
        .rstn_i      (tx_rstn),
        .in_data_i   (tx_wr_data),
        .in_valid_i  (tx_wr_valid),
        .in_ready_o  (tx_wr_ready),
        .out_data_o  (ser_data),
        .out_valid_o (ser_valid),
        .out_ready_i (ser_ready),
        .full_o      (tx_fifo_full),
        .empty_o     (tx_fifo_empty)
    );

    uart_fifo #(
        .DEPTH     (`UART_FIFO_DEPTH),
        .payload_t (uart_pkg::rx_word_t)
    ) u_rx_fifo (
        .clk_i       (clk_i),
        .rstn_i      (rx_rstn),
        .in_data_i   (des_word),
        .in_valid_i  (des_valid),
        .in_ready_o  (des_ready),
        .out_data_o  (rx_rd_word),
        .out_valid_o (rx_rd_valid),
        .out_ready_i (rx_rd_ready),
        .full_o      (rx_fifo_full),
        .empty_o     ()  // Status takes receive empty from the output valid
    );

    uart_tx u_tx (
        .clk_i     (clk_i),
        .rstn_i    (tx_rstn),
        .clk_div_i (clk_div),
        .control_i (control),
        .data_i    (ser_data),
        .valid_i   (ser_valid),
        .ready_o   (ser_ready),
        .uart_tx_o (uart_tx_o)
    );

    uart_rx u_rx (
        .clk_i     (clk_i),
        .rstn_i    (rx_rstn),
        .clk_div_i (clk_div),
        .control_i (control),
        .uart_rx_i (uart_rx_i),
        .word_o    (des_word),
        .valid_o   (des_valid),
        .ready_i   (des_ready)
    );

endmodule

// ==== sim/tb_apb_uart.sv ====
// Testbench for the APB UART covering registers, loopback, bit timing, parity errors and back-pressure
`timescale 1ns/1ps
`include "uart_params.svh"

module tb_apb_uart;

    localparam int NBYTES      = 8;
    localparam int DIV_FAST    = 3;
    localparam int DIV_SLOW    = 200;
    localparam int FRAMES      = 3 * NBYTES + 1;
    localparam int CYCLE_LIMIT = FRAMES * 11 * (DIV_FAST + 1) + 3000;

    logic               clk;
    logic               rstn;
    uart_pkg::apb_req_t apb_req;
    uart_pkg::apb_rsp_t apb_rsp;
    logic               uart_rx;
    logic               uart_tx;
    logic               loop_en;
    logic               inj_line;
    logic               timing_on;
    logic               cur_par;
    logic               tx_prev;
    logic               in_frame;
    logic               bit_lvl;
    int                 cur_div;
    int                 bit_cyc;
    int                 bit_num;
    int                 frames_seen;
    int                 mon_errs;
    int                 err_cnt;
    int                 test_errs;
    int                 tests_run;
    int                 tests_ok;
    int                 cycles;
    int                 seed;
    string              cur_test;
    logic [7:0]         sent_q[$];

    apb_uart u_dut (
        .clk_i     (clk),
        .rstn_i    (rstn),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .uart_rx_i (uart_rx),
        .uart_tx_o (uart_tx)
    );

    assign uart_rx = loop_en ? uart_tx : inj_line;  // Loopback or handmade frames

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("Timeout after %0d cycles while running %s", cycles, cur_test);
                $display("tests failed");
                $finish;
            end
        end
    end

    // The slave has no error cases
    assert property (@(posedge clk) disable iff (!rstn) !apb_rsp.pslverr)
        else begin
            err_cnt++;
            $display("APB slave raised pslverr in cycle %0d", cycles);
        end

    // Follows uart_tx one bit period at a time
    always @(posedge clk) begin
        tx_prev <= uart_tx;
        if (!rstn || !timing_on) begin
            in_frame <= 1'b0;
        end else if (!in_frame) begin
            if (tx_prev && !uart_tx) begin
                in_frame <= 1'b1;
                bit_cyc  <= 1;
                bit_num  <= 0;
                bit_lvl  <= 1'b0;
            end
        end else if (bit_cyc == cur_div + 1) begin
            if (bit_num == (cur_par ? 10 : 9)) begin
                assert (uart_tx) else begin
                    mon_errs++;
                    $display("Fail bit_timing: expected 1, actual 0 after the stop bit");
                end
                in_frame <= 1'b0;
                frames_seen++;
            end else begin
                if (bit_num + 1 == (cur_par ? 10 : 9)) begin  // Stop bit begins here
                    assert (uart_tx) else begin
                        mon_errs++;
                        $display("Fail bit_timing: expected 1, actual 0 in the stop bit");
                    end
                end
                bit_num <= bit_num + 1;
                bit_cyc <= 1;
                bit_lvl <= uart_tx;
            end
        end else begin
            assert (uart_tx == bit_lvl) else begin
                mon_errs++;
                $display("Fail bit_timing: expected %0b, actual %0b in bit %0d",
                         bit_lvl, uart_tx, bit_num);
            end
            bit_cyc <= bit_cyc + 1;
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            err_cnt++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = err_cnt;
    endtask

    task automatic end_test;
        tests_run++;
        if (err_cnt == test_errs) begin
            tests_ok++;
        end
        $display("%-20s %s", cur_test, (err_cnt == test_errs) ? "ok" : "error");
    endtask

    task automatic apb_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;
        @(posedge clk);  // This edge completes the access
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused_rd;
        apb_access(1'b1, addr, data, unused_rd);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        apb_access(1'b0, addr, 32'h0, data);
    endtask

    task automatic wait_rx_byte;
        logic [31:0] st;
        st = 32'h1;
        while (st[0]) begin
            apb_read(`UART_STATUS_ADDR, st);
        end
    endtask

    task automatic wait_line_idle;
        while (in_frame) begin
            @(posedge clk);
        end
    endtask

    // Start, data LSB first, parity, stop, each held for divider plus one cycles
    task automatic send_frame(input logic [7:0] data, input logic par_bit);
        logic [10:0] bits;
        bits = {1'b1, par_bit, data, 1'b0};
        repeat (11) begin
            @(posedge clk);
            inj_line <= bits[0];
            bits = bits >> 1;
            repeat (cur_div) @(posedge clk);
        end
    endtask

    task automatic run_loopback(input string name, input logic [31:0] ctrl, input logic par);
        logic [7:0]  b;
        logic [31:0] rd;
        begin_test(name);
        wait_line_idle();
        cur_par = par;
        apb_write(`UART_CONTROL_ADDR, ctrl);
        for (int i = 0; i < NBYTES; i++) begin
            b = 8'($random(seed));
            sent_q.push_back(b);
            apb_write(`UART_TX_DATA_ADDR, {24'h0, b});
        end
        while (sent_q.size() > 0) begin
            wait_rx_byte();
            apb_read(`UART_STATUS_ADDR, rd);
            check(name, 32'h0, rd & 32'h10);
            apb_read(`UART_RX_DATA_ADDR, rd);
            b = sent_q.pop_front();
            check(name, {24'h0, b}, rd);
        end
        end_test();
    endtask

    initial begin
        logic [31:0] rd;
        logic [7:0]  b;
        seed        = 32'h9a6d;
        rstn        = 1'b0;
        apb_req     = '0;
        loop_en     = 1'b0;
        inj_line    = 1'b1;
        timing_on   = 1'b0;
        cur_par     = 1'b0;
        cur_div     = 0;
        tx_prev     = 1'b1;
        in_frame    = 1'b0;
        frames_seen = 0;
        mon_errs    = 0;
        err_cnt     = 0;
        tests_run   = 0;
        tests_ok    = 0;
        cur_test    = "reset";
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        begin_test("reset_state");
        check(cur_test, 32'h1, {31'h0, uart_tx});
        apb_read(`UART_STATUS_ADDR, rd);
        check(cur_test, 32'h3, rd);  // Both FIFOs empty, nothing else set
        apb_read(`UART_CLK_DIV_ADDR, rd);
        check(cur_test, 32'h0, rd);
        apb_read(`UART_CONTROL_ADDR, rd);
        check(cur_test, 32'h0, rd);
        apb_write(`UART_CLK_DIV_ADDR, 32'h0000_a5c3);
        apb_write(`UART_CONTROL_ADDR, 32'h0000_0003);
        apb_read(`UART_CLK_DIV_ADDR, rd);
        check(cur_test, 32'h0000_a5c3, rd);
        apb_read(`UART_CONTROL_ADDR, rd);
        check(cur_test, 32'h0000_0003, rd);
        end_test();

        cur_div = DIV_FAST;
        apb_write(`UART_CLK_DIV_ADDR, 32'(DIV_FAST));
        loop_en   <= 1'b1;
        timing_on <= 1'b1;
        run_loopback("loopback_none", 32'h0, 1'b0);
        run_loopback("loopback_even", 32'h1, 1'b1);
        run_loopback("loopback_odd", 32'h2, 1'b1);

        wait_line_idle();
        begin_test("bit_timing");
        check(cur_test, 32'(3 * NBYTES), 32'(frames_seen));
        check(cur_test, 32'h0, 32'(mon_errs));
        end_test();

        begin_test("parity_error");
        loop_en <= 1'b0;
        apb_write(`UART_CONTROL_ADDR, 32'h1);
        b = 8'($random(seed));
        send_frame(b, ~(^b));  // Even parity with the wrong bit
        wait_rx_byte();
        apb_read(`UART_STATUS_ADDR, rd);
        check(cur_test, 32'h10, rd & 32'h10);
        apb_read(`UART_RX_DATA_ADDR, rd);
        check(cur_test, {24'h0, b}, rd);
        end_test();

        begin_test("backpressure_flush");
        timing_on <= 1'b0;
        cur_div = DIV_SLOW;
        apb_write(`UART_CLK_DIV_ADDR, 32'(DIV_SLOW));
        apb_write(`UART_CONTROL_ADDR, 32'h0);
        for (int i = 0; i < `UART_FIFO_DEPTH + 1; i++) begin
            apb_write(`UART_TX_DATA_ADDR, 32'(i));
        end
        apb_read(`UART_STATUS_ADDR, rd);
        check(cur_test, 32'h8, rd & 32'h8);
        apb_write(`UART_CONTROL_ADDR, 32'h4);
        apb_write(`UART_CONTROL_ADDR, 32'h0);
        apb_read(`UART_STATUS_ADDR, rd);
        check(cur_test, 32'h3, rd);
        end_test();

        $display("Tests run %0d, ok %0d, checks with errors %0d, timing errors %0d",
                 tests_run, tests_ok, err_cnt, mon_errs);
        if (err_cnt == 0 && mon_errs == 0 && tests_ok == tests_run) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
hw/uart_pkg.sv
hw/uart_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_apb_regs.sv
hw/apb_uart.sv
sim/tb_apb_uart.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_apb_uart
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
